// File: include/island_defs.svh
// Memory island sizing: address, data, strobe, bank count and bank depth
`ifndef ISLAND_DEFS_SVH
`define ISLAND_DEFS_SVH

// ----------------------------------------
// Address space
// ----------------------------------------
// Byte address, 4 KiB island
`define ISL_ADDR_W 12

// ----------------------------------------
// Port widths
// ----------------------------------------
// Narrow requestor word
`define ISL_NDATA_W 32
// Wide requestor word, two narrow lanes
`define ISL_WDATA_W 64
// One strobe bit per byte
`define ISL_NSTRB_W 4
`define ISL_WSTRB_W 8

// ----------------------------------------
// Banking
// ----------------------------------------
// Narrow banks, paired for wide access
`define ISL_NUM_BANKS 4
// Words in each single-port bank
`define ISL_BANK_WORDS 256
// Row index inside a bank
`define ISL_ROW_W 8

`endif

// File: source/island_pkg.sv
// Shared memory island types: wide word view, bank and pair indices, narrow word
`include "island_defs.svh"

package island_pkg;

    // ----------------------------------------
    // Narrow data path
    // ----------------------------------------
    // One bank word
    typedef logic [`ISL_NDATA_W-1:0] ndata_t;

    // Byte enables for one bank word
    typedef logic [`ISL_NSTRB_W-1:0] nstrb_t;

    // ----------------------------------------
    // Bank selection
    // ----------------------------------------
    // Narrow bank number, taken from addr[3:2]
    typedef logic [$clog2(`ISL_NUM_BANKS)-1:0] bank_idx_t;

    // Bank pair number, taken from addr[3] on the wide port
    // Pair p covers banks 2p (even) and 2p+1 (odd)
    typedef logic [$clog2(`ISL_NUM_BANKS)-2:0] pair_idx_t;

    // ----------------------------------------
    // Wide data path
    // ----------------------------------------
    // Wide word seen as a whole or as two bank lanes
    // lane[0] is the low half, stored in the even bank
    // lane[1] is the high half, stored in the odd bank
    typedef union packed {
        logic [`ISL_WDATA_W-1:0] word;
        ndata_t [1:0]            lane;
    } wide_word_u;

endpackage

// File: source/bank_req_if.sv
// Single bank request bundle between a requester and one SRAM bank slice
`timescale 1ns/1ps
`include "island_defs.svh"

interface bank_req_if;

    // Request strobe, one cycle per access
    logic                    valid;
    // High for write, low for read
    logic                    write;
    // Word row inside the bank
    logic [`ISL_ROW_W-1:0]   row;
    // Write payload and byte enables
    island_pkg::ndata_t      wdata;
    island_pkg::nstrb_t      strb;

    // Control or splitter side
    modport requester (
        output valid,
        output write,
        output row,
        output wdata,
        output strb
    );

    // Bank slice side
    modport bank (
        input valid,
        input write,
        input row,
        input wdata,
        input strb
    );

endinterface

// File: source/island_ctrl.sv
// Island control: narrow bank decode, wide pair grant and response tracking
`timescale 1ns/1ps
`include "island_defs.svh"

module island_ctrl (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,

    // Narrow request and response
    input  logic                                       n_q_valid_i,
    input  logic                                       n_q_write_i,
    input  logic [`ISL_ADDR_W-1:0]                     n_q_addr_i,
    input  island_pkg::ndata_t                         n_q_wdata_i,
    input  island_pkg::nstrb_t                         n_q_strb_i,
    output logic                                       n_q_ready_o,
    output logic                                       n_p_valid_o,
    output island_pkg::ndata_t                         n_p_rdata_o,

    // Wide request arbitration
    input  logic                                       w_q_valid_i,
    input  island_pkg::pair_idx_t                      w_q_addr_pair_i,
    output logic                                       w_q_ready_o,
    output logic                                       w_grant_o,
    output island_pkg::pair_idx_t                      w_pair_o,
    output island_pkg::pair_idx_t                      w_rsp_pair_o,
    output logic                                       w_p_valid_o,

    // Bank side
    input  island_pkg::ndata_t [`ISL_NUM_BANKS-1:0]    bank_rdata_i,
    output logic [`ISL_NUM_BANKS-1:0]                  wide_sel_o,
    bank_req_if.requester                              nreq_bus [`ISL_NUM_BANKS]
);

    // Byte offset below the bank field, row above the pair field
    localparam int unsigned BANK_LSB   = $clog2(`ISL_NSTRB_W);
    localparam int unsigned BANK_IDX_W = $bits(island_pkg::bank_idx_t);
    localparam int unsigned ROW_LSB    = BANK_LSB + BANK_IDX_W;

    island_pkg::bank_idx_t  n_bank;
    island_pkg::pair_idx_t  n_pair;
    logic [`ISL_ROW_W-1:0]  n_row;
    logic                   pair_busy;

    island_pkg::bank_idx_t  n_bank_q;
    island_pkg::pair_idx_t  w_pair_q;
    logic                   n_p_valid_q;
    logic                   w_p_valid_q;

    // ----------------------------------------
    // Narrow decode
    // ----------------------------------------
    assign n_bank = n_q_addr_i[BANK_LSB +: BANK_IDX_W];
    assign n_row  = n_q_addr_i[ROW_LSB +: `ISL_ROW_W];
    // Upper bank bit names the pair
    assign n_pair = island_pkg::pair_idx_t'(n_bank >> 1);

    // Narrow has priority, never stalled
    assign n_q_ready_o = 1'b1;

    // One request lands only in the addressed bank
    for (genvar g = 0; g < `ISL_NUM_BANKS; g++) begin : gen_nreq
        assign nreq_bus[g].valid = n_q_valid_i && (n_bank == island_pkg::bank_idx_t'(g));
        assign nreq_bus[g].write = n_q_write_i;
        assign nreq_bus[g].row   = n_row;
        assign nreq_bus[g].wdata = n_q_wdata_i;
        assign nreq_bus[g].strb  = n_q_strb_i;
    end

    // ----------------------------------------
    // Wide arbitration
    // ----------------------------------------
    // Narrow in either bank of the pair blocks wide
    assign pair_busy   = n_q_valid_i && (n_pair == w_q_addr_pair_i);
    assign w_q_ready_o = !pair_busy;
    assign w_grant_o   = w_q_valid_i && !pair_busy;
    assign w_pair_o    = w_q_addr_pair_i;

    // Hand both banks of the granted pair to the splitter
    for (genvar g = 0; g < `ISL_NUM_BANKS; g++) begin : gen_wsel
        assign wide_sel_o[g] = w_grant_o &&
                               (w_q_addr_pair_i == island_pkg::pair_idx_t'(g >> 1));
    end

    // ----------------------------------------
    // Response tracking
    // ----------------------------------------
    // Valids follow acceptance by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            n_p_valid_q <= 1'b0;
            w_p_valid_q <= 1'b0;
        end else begin
            n_p_valid_q <= n_q_valid_i;
            w_p_valid_q <= w_grant_o;
        end
    end

    // Steering for the read mux, only meaningful with its valid
    always_ff @(posedge clk_i) begin
        if (n_q_valid_i) begin
            n_bank_q <= n_bank;
        end
        if (w_grant_o) begin
            w_pair_q <= w_q_addr_pair_i;
        end
    end

    assign n_p_valid_o  = n_p_valid_q;
    assign w_p_valid_o  = w_p_valid_q;
    assign w_rsp_pair_o = w_pair_q;

    // Read word from the bank the narrow port used last cycle
    assign n_p_rdata_o = bank_rdata_i[n_bank_q];

endmodule

// File: source/wide_splitter.sv
// Wide splitter: cuts wide requests into two bank lanes and rebuilds wide read data
`timescale 1ns/1ps
`include "island_defs.svh"

module wide_splitter (
    // Wide request payload
    input  logic                                       w_q_write_i,
    input  logic [`ISL_ADDR_W-1:0]                     w_q_addr_i,
    input  island_pkg::wide_word_u                     w_q_wdata_i,
    input  logic [`ISL_WSTRB_W-1:0]                    w_q_strb_i,

    // Grant and pair from control
    input  logic                                       w_grant_i,
    input  island_pkg::pair_idx_t                      w_pair_i,
    input  island_pkg::pair_idx_t                      w_rsp_pair_i,

    // Read path
    input  island_pkg::ndata_t [`ISL_NUM_BANKS-1:0]    bank_rdata_i,
    output island_pkg::wide_word_u                     w_p_rdata_o,

    // Lane requests, one per bank
    bank_req_if.requester                              wreq_bus [`ISL_NUM_BANKS]
);

    // Wide word offset, then pair bit, then row
    localparam int unsigned PAIR_LSB = $clog2(`ISL_WSTRB_W);
    localparam int unsigned ROW_LSB  = PAIR_LSB + $bits(island_pkg::pair_idx_t);

    logic [`ISL_ROW_W-1:0] w_row;

    assign w_row = w_q_addr_i[ROW_LSB +: `ISL_ROW_W];

    // ----------------------------------------
    // Request split
    // ----------------------------------------
    // Bank g takes lane g%2 when its pair g/2 is granted
    for (genvar g = 0; g < `ISL_NUM_BANKS; g++) begin : gen_lane
        localparam int unsigned LANE = g % 2;

        assign wreq_bus[g].valid = w_grant_i &&
                                   (w_pair_i == island_pkg::pair_idx_t'(g >> 1));
        assign wreq_bus[g].write = w_q_write_i;
        assign wreq_bus[g].row   = w_row;
        assign wreq_bus[g].wdata = w_q_wdata_i.lane[LANE];
        // Strobe halves line up with the data lanes
        assign wreq_bus[g].strb  = w_q_strb_i[LANE*`ISL_NSTRB_W +: `ISL_NSTRB_W];
    end

    // ----------------------------------------
    // Read merge
    // ----------------------------------------
    // Pair index is last cycle's grant, in step with bank read data
    always_comb begin
        w_p_rdata_o.lane[0] = bank_rdata_i[{w_rsp_pair_i, 1'b0}];
        w_p_rdata_o.lane[1] = bank_rdata_i[{w_rsp_pair_i, 1'b1}];
    end

endmodule

// File: source/bank_slice.sv
// Bank slice: narrow/wide request mux in front of one byte-enabled single-port SRAM
`timescale 1ns/1ps
`include "island_defs.svh"

module bank_slice (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Competing requests for this bank
    bank_req_if.bank           nreq,
    bank_req_if.bank           wreq,
    // High when the wide port owns the bank this cycle
    input  logic               wide_sel_i,

    output island_pkg::ndata_t rdata_o
);

    logic                  sel_valid;
    logic                  sel_write;
    logic [`ISL_ROW_W-1:0] sel_row;
    island_pkg::ndata_t    sel_wdata;
    island_pkg::nstrb_t    sel_strb;

    island_pkg::ndata_t    mem_q [`ISL_BANK_WORDS];
    island_pkg::ndata_t    rdata_q;

    // ----------------------------------------
    // Access mux
    // ----------------------------------------
    // Control never selects wide while narrow uses the bank
    always_comb begin
        if (wide_sel_i) begin
            sel_valid = wreq.valid;
            sel_write = wreq.write;
            sel_row   = wreq.row;
            sel_wdata = wreq.wdata;
            sel_strb  = wreq.strb;
        end else begin
            sel_valid = nreq.valid;
            sel_write = nreq.write;
            sel_row   = nreq.row;
            sel_wdata = nreq.wdata;
            sel_strb  = nreq.strb;
        end
    end

    // ----------------------------------------
    // SRAM array
    // ----------------------------------------
    // Byte-enabled write
    always_ff @(posedge clk_i) begin
        if (sel_valid && sel_write) begin
            for (int b = 0; b < `ISL_NSTRB_W; b++) begin
                if (sel_strb[b]) begin
                    mem_q[sel_row][8*b +: 8] <= sel_wdata[8*b +: 8];
                end
            end
        end
    end

    // Read word out one cycle later, held until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (sel_valid && !sel_write) begin
            rdata_q <= mem_q[sel_row];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// File: source/mem_island_top.sv
// Memory island top: narrow and wide ports over four shared 32-bit SRAM banks
`timescale 1ns/1ps
`include "island_defs.svh"

module mem_island_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Narrow port, 32-bit
    input  logic                        n_q_valid_i,
    output logic                        n_q_ready_o,
    input  logic [`ISL_ADDR_W-1:0]      n_q_addr_i,
    input  logic                        n_q_write_i,
    input  logic [`ISL_NDATA_W-1:0]     n_q_wdata_i,
    input  logic [`ISL_NSTRB_W-1:0]     n_q_strb_i,
    output logic                        n_p_valid_o,
    output logic [`ISL_NDATA_W-1:0]     n_p_rdata_o,

    // Wide port, 64-bit
    input  logic                        w_q_valid_i,
    output logic                        w_q_ready_o,
    input  logic [`ISL_ADDR_W-1:0]      w_q_addr_i,
    input  logic                        w_q_write_i,
    input  logic [`ISL_WDATA_W-1:0]     w_q_wdata_i,
    input  logic [`ISL_WSTRB_W-1:0]     w_q_strb_i,
    output logic                        w_p_valid_o,
    output logic [`ISL_WDATA_W-1:0]     w_p_rdata_o
);

    // Pair bit sits just above the wide byte offset
    localparam int unsigned PAIR_LSB = $clog2(`ISL_WSTRB_W);

    island_pkg::wide_word_u                    w_wdata;
    island_pkg::wide_word_u                    w_rdata;
    island_pkg::pair_idx_t                     w_addr_pair;
    island_pkg::pair_idx_t                     w_pair;
    island_pkg::pair_idx_t                     w_rsp_pair;
    logic                                      w_grant;
    logic [`ISL_NUM_BANKS-1:0]                 wide_sel;
    island_pkg::ndata_t [`ISL_NUM_BANKS-1:0]   bank_rdata;

    // Per-bank request buses, narrow and wide
    bank_req_if nreq_bus [`ISL_NUM_BANKS] ();
    bank_req_if wreq_bus [`ISL_NUM_BANKS] ();

    assign w_wdata.word = w_q_wdata_i;
    assign w_p_rdata_o  = w_rdata.word;
    assign w_addr_pair  = w_q_addr_i[PAIR_LSB +: $bits(island_pkg::pair_idx_t)];

    // ----------------------------------------
    // Control and wide split
    // ----------------------------------------
    island_ctrl ctrl_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .n_q_valid_i     (n_q_valid_i),
        .n_q_write_i     (n_q_write_i),
        .n_q_addr_i      (n_q_addr_i),
        .n_q_wdata_i     (n_q_wdata_i),
        .n_q_strb_i      (n_q_strb_i),
        .n_q_ready_o     (n_q_ready_o),
        .n_p_valid_o     (n_p_valid_o),
        .n_p_rdata_o     (n_p_rdata_o),
        .w_q_valid_i     (w_q_valid_i),
        .w_q_addr_pair_i (w_addr_pair),
        .w_q_ready_o     (w_q_ready_o),
        .w_grant_o       (w_grant),
        .w_pair_o        (w_pair),
        .w_rsp_pair_o    (w_rsp_pair),
        .w_p_valid_o     (w_p_valid_o),
        .bank_rdata_i    (bank_rdata),
        .wide_sel_o      (wide_sel),
        .nreq_bus        (nreq_bus)
    );

    wide_splitter splitter_i (
        .w_q_write_i  (w_q_write_i),
        .w_q_addr_i   (w_q_addr_i),
        .w_q_wdata_i  (w_wdata),
        .w_q_strb_i   (w_q_strb_i),
        .w_grant_i    (w_grant),
        .w_pair_i     (w_pair),
        .w_rsp_pair_i (w_rsp_pair),
        .bank_rdata_i (bank_rdata),
        .w_p_rdata_o  (w_rdata),
        .wreq_bus     (wreq_bus)
    );

    // ----------------------------------------
    // Banks
    // ----------------------------------------
    for (genvar g = 0; g < `ISL_NUM_BANKS; g++) begin : gen_bank
        bank_slice bank_i (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .nreq       (nreq_bus[g]),
            .wreq       (wreq_bus[g]),
            .wide_sel_i (wide_sel[g]),
            .rdata_o    (bank_rdata[g])
        );
    end

endmodule

// File: tb/tb_clkgen.sv
// Testbench clock and reset source, 20 ns clock with reset held for five cycles
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release just after an edge, in step with the stimulus
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_no = 1'b1;
    end

endmodule

// File: tb/tb_mem_island.sv
// Memory island testbench with directed and random narrow/wide traffic against a model memory
`timescale 1ns/1ps
`include "island_defs.svh"

module tb_mem_island;

    localparam int WAIT_LIMIT = 20;
    localparam int RANDOM_OPS = 300;

    // One outstanding response
    // Narrow data rides in lane 0
    typedef struct packed {
        island_pkg::wide_word_u data;
        logic                   is_read;
        logic [31:0]            cyc;
    } exp_t;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    n_q_valid_i, n_q_ready_o, n_q_write_i, n_p_valid_o;
    logic [`ISL_ADDR_W-1:0]  n_q_addr_i;
    island_pkg::ndata_t      n_q_wdata_i;
    island_pkg::ndata_t      n_p_rdata_o;
    island_pkg::nstrb_t      n_q_strb_i;
    logic                    w_q_valid_i, w_q_ready_o, w_q_write_i, w_p_valid_o;
    logic [`ISL_ADDR_W-1:0]  w_q_addr_i;
    logic [`ISL_WDATA_W-1:0] w_q_wdata_i;
    logic [`ISL_WDATA_W-1:0] w_p_rdata_o;
    logic [`ISL_WSTRB_W-1:0] w_q_strb_i;

    // Model memory indexed by bank then row
    island_pkg::ndata_t model_mem [`ISL_NUM_BANKS][`ISL_BANK_WORDS];
    exp_t               n_exp_q [$];
    exp_t               w_exp_q [$];
    int                 cyc = 0;
    int                 errors = 0;
    int                 test_errors = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    string              test_name = "reset";

    tb_clkgen clkgen_i (.clk_o(clk_i), .rst_no(rst_ni));

    mem_island_top dut_i (.*);

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic void model_write(input int bank, input int row,
            input island_pkg::ndata_t data, input island_pkg::nstrb_t strb);
        for (int b = 0; b < `ISL_NSTRB_W; b++) begin
            if (strb[b]) begin
                model_mem[bank][row][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // Narrow bank is addr[3:2], wide pair is addr[3], row is addr[11:4]
    function automatic island_pkg::wide_word_u ref_read(input logic wide,
            input logic [`ISL_ADDR_W-1:0] addr);
        island_pkg::wide_word_u res;
        island_pkg::bank_idx_t  bank;
        bank     = addr[3:2];
        res.word = '0;
        if (wide) begin
            res.lane[0] = model_mem[{addr[3], 1'b0}][addr[11:4]];
            res.lane[1] = model_mem[{addr[3], 1'b1}][addr[11:4]];
        end else begin
            res.lane[0] = model_mem[bank][addr[11:4]];
        end
        return res;
    endfunction

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic report_problem(input string msg);
        $display("[ERROR] %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_narrow(input string what, input island_pkg::ndata_t exp,
            input island_pkg::ndata_t act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_wide(input string what, input island_pkg::wide_word_u exp,
            input island_pkg::wide_word_u act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what,
                     exp.word, act.word);
            errors++;
        end
    endtask

    // Sampled mid-cycle away from the clock edge
    always @(negedge clk_i) begin
        exp_t e;
        if (rst_ni && n_p_valid_o) begin
            if (n_exp_q.size() == 0) begin
                report_problem("narrow response with no request outstanding");
            end else begin
                e = n_exp_q.pop_front();
                if (e.cyc + 1 != cyc) begin
                    report_problem("narrow response not one cycle after its accept");
                end
                if (e.is_read) begin
                    check_narrow("narrow read", e.data.lane[0], n_p_rdata_o);
                end
            end
        end
        if (rst_ni && w_p_valid_o) begin
            if (w_exp_q.size() == 0) begin
                report_problem("wide response with no request outstanding");
            end else begin
                e = w_exp_q.pop_front();
                if (e.cyc + 1 != cyc) begin
                    report_problem("wide response not one cycle after its accept");
                end
                if (e.is_read) begin
                    check_wide("wide read", e.data, w_p_rdata_o);
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    // One request cycle
    // A stalled wide request is held until granted
    task automatic issue(input logic nv, input logic nw, input logic [`ISL_ADDR_W-1:0] na,
            input island_pkg::ndata_t nd, input island_pkg::nstrb_t ns,
            input logic wv, input logic ww, input logic [`ISL_ADDR_W-1:0] wa,
            input island_pkg::wide_word_u wd, input logic [`ISL_WSTRB_W-1:0] ws,
            output logic first_ready);
        int   waited;
        exp_t e;
        logic exp_ready;
        n_q_valid_i = nv;
        n_q_write_i = nw;
        n_q_addr_i  = na;
        n_q_wdata_i = nd;
        n_q_strb_i  = ns;
        w_q_valid_i = wv;
        w_q_write_i = ww;
        w_q_addr_i  = wa;
        w_q_wdata_i = wd.word;
        w_q_strb_i  = ws;
        // Wide stalls only when narrow sits in the same bank pair
        exp_ready   = !(nv && (na[3] == wa[3]));
        @(negedge clk_i);
        first_ready = w_q_ready_o;
        check_flag("n_q_ready_o", 1'b1, n_q_ready_o);
        check_flag("w_q_ready_o", exp_ready, first_ready);
        if (nv) begin
            e.data    = ref_read(1'b0, na);
            e.is_read = !nw;
            e.cyc     = cyc;
            n_exp_q.push_back(e);
            if (nw) begin
                model_write(na[3:2], na[11:4], nd, ns);
            end
        end
        waited = 0;
        while (wv && !w_q_ready_o && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            #2;
            n_q_valid_i = 1'b0;
            waited++;
            @(negedge clk_i);
        end
        if (wv && !w_q_ready_o) begin
            report_problem("wide request never granted");
        end else if (wv) begin
            e.data    = ref_read(1'b1, wa);
            e.is_read = !ww;
            e.cyc     = cyc;
            w_exp_q.push_back(e);
            if (ww) begin
                model_write({wa[3], 1'b0}, wa[11:4], wd.lane[0], ws[3:0]);
                model_write({wa[3], 1'b1}, wa[11:4], wd.lane[1], ws[7:4]);
            end
        end
        @(posedge clk_i);
        #2;
        n_q_valid_i = 1'b0;
        w_q_valid_i = 1'b0;
    endtask

    // Drain outstanding responses then print one line for the test
    task automatic finish_test();
        int waited;
        waited = 0;
        while ((n_exp_q.size() != 0 || w_exp_q.size() != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            #2;
            waited++;
        end
        if (n_exp_q.size() != 0 || w_exp_q.size() != 0) begin
            report_problem("responses still missing after the timeout");
            n_exp_q.delete();
            w_exp_q.delete();
        end
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %-14s failed, %0d errors", test_name, errors - test_errors);
        end else begin
            $display("test %-14s passed", test_name);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    initial begin
        int                     waited;
        logic                   rdy;
        logic [7:0]             row;
        logic [`ISL_ADDR_W-1:0] addr;
        island_pkg::wide_word_u wd;
        void'($urandom(26235));
        n_q_valid_i = 1'b0;
        n_q_write_i = 1'b0;
        n_q_addr_i  = '0;
        n_q_wdata_i = '0;
        n_q_strb_i  = '0;
        w_q_valid_i = 1'b0;
        w_q_write_i = 1'b0;
        w_q_addr_i  = '0;
        w_q_wdata_i = '0;
        w_q_strb_i  = '0;
        waited = 0;
        while (rst_ni !== 1'b1 && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        @(posedge clk_i);
        #2;

        start_test("reset_idle");
        if (rst_ni !== 1'b1) begin
            report_problem("reset was never released");
        end
        repeat (4) begin
            @(negedge clk_i);
            if (n_p_valid_o || w_p_valid_o || !n_q_ready_o || !w_q_ready_o) begin
                report_problem("port flags wrong while idle after reset");
            end
            @(posedge clk_i);
            #2;
        end
        finish_test();

        // Every wide word gets a pattern built from its full address
        start_test("fill");
        for (int i = 0; i < 2 * `ISL_BANK_WORDS; i++) begin
            addr        = `ISL_ADDR_W'(i << 3);
            wd.lane[0] = {8'hA0, 4'h0, addr, 8'h0F};
            wd.lane[1] = {8'hB1, 4'h0, addr, 8'hF0};
            issue(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b1, addr, wd, 8'hFF, rdy);
        end
        finish_test();

        start_test("narrow_strobe");
        for (int b = 0; b < `ISL_NUM_BANKS; b++) begin
            row  = $urandom_range(255);
            addr = {row, 2'(b), 2'b00};
            issue(1'b1, 1'b1, addr, $urandom, 4'b1001 ^ 4'(b), 1'b0, 1'b0, '0, '0, '0, rdy);
            issue(1'b1, 1'b0, addr, '0, '0, 1'b0, 1'b0, '0, '0, '0, rdy);
        end
        finish_test();

        // Lane 0 lands in the even bank, lane 1 in the odd bank
        start_test("wide_lanes");
        for (int p = 0; p < 2; p++) begin
            row     = $urandom_range(255);
            wd.word = {$urandom, $urandom};
            issue(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b1, {row, p[0], 3'b000}, wd, 8'hFF, rdy);
            issue(1'b1, 1'b0, {row, p[0], 3'b000}, '0, '0, 1'b0, 1'b0, '0, '0, '0, rdy);
            issue(1'b1, 1'b0, {row, p[0], 3'b100}, '0, '0, 1'b0, 1'b0, '0, '0, '0, rdy);
            issue(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0, {row, p[0], 3'b000}, '0, '0, rdy);
        end
        finish_test();

        // Same pair so narrow goes first and wide waits a cycle
        start_test("pair_collide");
        for (int p = 0; p < 2; p++) begin
            row     = $urandom_range(255);
            wd.word = {$urandom, $urandom};
            issue(1'b1, 1'b1, {row, p[0], 3'b100}, $urandom, 4'hF,
                  1'b1, 1'b1, {row, p[0], 3'b000}, wd, 8'hFF, rdy);
            if (rdy) begin
                report_problem("w_q_ready_o high while narrow uses the same pair");
            end
            issue(1'b1, 1'b0, {row, p[0], 3'b000}, '0, '0,
                  1'b1, 1'b0, {row, p[0], 3'b000}, '0, '0, rdy);
            if (rdy) begin
                report_problem("w_q_ready_o high while narrow reads the same pair");
            end
        end
        finish_test();

        // Different pairs are both accepted in one cycle
        start_test("pair_parallel");
        for (int p = 0; p < 2; p++) begin
            row     = $urandom_range(255);
            wd.word = {$urandom, $urandom};
            issue(1'b1, 1'b1, {row, !p[0], 3'b100}, $urandom, 4'hF,
                  1'b1, 1'b1, {row, p[0], 3'b000}, wd, 8'hFF, rdy);
            if (!rdy) begin
                report_problem("w_q_ready_o low although the pairs differ");
            end
            issue(1'b1, 1'b0, {row, !p[0], 3'b100}, '0, '0,
                  1'b1, 1'b0, {row, p[0], 3'b000}, '0, '0, rdy);
            if (!rdy) begin
                report_problem("w_q_ready_o low on reads to different pairs");
            end
        end
        finish_test();

        start_test("random_mix");
        for (int k = 0; k < RANDOM_OPS; k++) begin
            wd.word = {$urandom, $urandom};
            issue($urandom_range(9) < 7, $urandom_range(1), `ISL_ADDR_W'($urandom),
                  $urandom, 4'($urandom), $urandom_range(1), $urandom_range(1),
                  `ISL_ADDR_W'($urandom), wd, 8'($urandom), rdy);
        end
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
source/island_pkg.sv
source/bank_req_if.sv
source/island_ctrl.sv
source/wide_splitter.sv
source/bank_slice.sv
source/mem_island_top.sv
tb/tb_clkgen.sv
tb/tb_mem_island.sv
